// File: Makefile
VERILATOR ?= verilator
TOP       ?= soc_top_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module bus_decoder (
    input  wire                           req_i,
    input  wire                           we_i,
    input  wire soc_bus_pkg::bus_addr_t   addr_i,
    output logic [`SRAM_BANKS-1:0]        sram_sel_o,
    output logic                          conf_sel_o,
    output soc_map_pkg::target_e          tgt_o,
    output logic                          rd_o
);

    logic sram0_hit;
    logic sram1_hit;
    logic conf_hit;

    // Region compares on the full address
    assign sram0_hit = (addr_i & `SRAM_MASK) == `SRAM0_BASE;
    assign sram1_hit = (addr_i & `SRAM_MASK) == `SRAM1_BASE;
    assign conf_hit  = (addr_i & `CONF_MASK) == `CONF_BASE;

    // Selects come straight from the hits while a request is up
    assign sram_sel_o = {req_i & sram1_hit, req_i & sram0_hit};
    assign conf_sel_o = req_i & conf_hit;
    assign rd_o       = req_i & ~we_i;

    always_comb
    begin
        if (sram0_hit)
            tgt_o = soc_map_pkg::TGT_SRAM0;
        else if (sram1_hit)
            tgt_o = soc_map_pkg::TGT_SRAM1;
        else if (conf_hit)
            tgt_o = soc_map_pkg::TGT_CONF;
        else
            tgt_o = soc_map_pkg::TGT_NONE;
    end

    // Regions in the memory map must never overlap
    always_comb
    begin
        assert ($onehot0({sram_sel_o, conf_sel_o}))
        else $error("bus_decoder: more than one target hit at %h", addr_i);
    end

endmodule

`default_nettype wire

// File: confreg.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module confreg (
    input  wire                          c1_clk0,
    input  wire                          reset_i,
    input  wire                          sel_i,
    input  wire                          we_i,
    input  wire soc_bus_pkg::bus_addr_t  addr_i,
    input  wire soc_bus_pkg::bus_strb_t  wstrb_i,
    input  wire soc_bus_pkg::bus_data_t  wdata_i,
    output soc_bus_pkg::bus_data_t       rdata_o,
    output logic [15:0]                  led_o,
    output logic [7:0]                   num_csn_o,
    output logic [7:0]                   num_a_g_o
);

    soc_bus_pkg::bus_data_t   regs [`CONF_REGS];
    soc_map_pkg::conf_index_t idx;

    assign idx = addr_i[$clog2(`CONF_REGS)+1:2];

    // Byte writable register file
    always_ff @(posedge c1_clk0)
    begin
        if (reset_i)
        begin
            for (int r = 0; r < `CONF_REGS; r++)
                regs[r] <= (r == 1) ? `CONF_CSN_RESET : '0;
        end
        else if (sel_i && we_i)
        begin
            for (int b = 0; b < `BUS_DW/8; b++)
            begin
                if (wstrb_i[b])
                    regs[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    // Read port answers one cycle after select
    always_ff @(posedge c1_clk0)
    begin
        if (sel_i && !we_i)
            rdata_o <= regs[idx];
    end

    // Board outputs from regs 0 to 2
    assign led_o     = regs[0][15:0];
    assign num_csn_o = regs[1][7:0];
    assign num_a_g_o = regs[2][7:0];

endmodule

`default_nettype wire

// File: list.f
+incdir+.
soc_bus_pkg.sv
soc_map_pkg.sv
bus_decoder.sv
sram_bank.sv
confreg.sv
read_return.sv
soc_top.sv
soc_top_tb.sv

// File: read_return.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module read_return (
    input  wire                          c1_clk0,
    input  wire                          reset_i,
    input  wire                          rd_i,
    input  wire soc_map_pkg::target_e    tgt_i,
    input  wire soc_bus_pkg::bus_data_t  sram_rdata_i [`SRAM_BANKS],
    input  wire soc_bus_pkg::bus_data_t  conf_rdata_i,
    output logic                         rvalid_o,
    output soc_bus_pkg::bus_data_t       rdata_o
);

    logic                 rd_q;
    soc_map_pkg::target_e tgt_q;

    // Remember which target answers next cycle
    always_ff @(posedge c1_clk0)
    begin
        if (reset_i)
        begin
            rd_q  <= 1'b0;
            tgt_q <= soc_map_pkg::TGT_NONE;
        end
        else
        begin
            rd_q  <= rd_i;
            tgt_q <= tgt_i;
        end
    end

    assign rvalid_o = rd_q;

    always_comb
    begin
        case (tgt_q)
            soc_map_pkg::TGT_SRAM0: rdata_o = sram_rdata_i[0];
            soc_map_pkg::TGT_SRAM1: rdata_o = sram_rdata_i[1];
            soc_map_pkg::TGT_CONF:  rdata_o = conf_rdata_i;
            // Unmapped reads return zero
            default:                rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: soc_bus_pkg.sv
`default_nettype none

`include "soc_params.svh"

package soc_bus_pkg;

    // Byte address on the strobe bus
    typedef logic [`BUS_AW-1:0] bus_addr_t;

    // One bus word
    typedef logic [`BUS_DW-1:0] bus_data_t;

    // One write strobe per byte lane
    typedef logic [`BUS_DW/8-1:0] bus_strb_t;

endpackage

`default_nettype wire

// File: soc_map_pkg.sv
`default_nettype none

`include "soc_params.svh"

package soc_map_pkg;

    // Where a request goes
    typedef enum logic [1:0] {
        TGT_SRAM0 = 2'd0,
        TGT_SRAM1 = 2'd1,
        TGT_CONF  = 2'd2,
        TGT_NONE  = 2'd3
    } target_e;

    // Word index inside one SRAM bank
    typedef logic [`SRAM_AW-1:0] sram_index_t;

    // Register number inside the config block
    typedef logic [$clog2(`CONF_REGS)-1:0] conf_index_t;

endpackage

`default_nettype wire

// File: soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define BUS_AW 32
`define BUS_DW 32

// Two tightly coupled SRAM banks of 8K words each
`define SRAM_BANKS 2
`define SRAM_AW    13

// Instruction bank first, data bank second
`define SRAM0_BASE 32'hbfff_8000
`define SRAM1_BASE 32'hbfff_0000
`define SRAM_MASK  32'hffff_8000

// Configuration register block of 8 words
`define CONF_BASE      32'hbfaf_0000
`define CONF_MASK      32'hffff_ffe0
`define CONF_REGS      8
`define CONF_CSN_RESET 32'h0000_00ff

`endif

// File: soc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_top (
    input  wire                          c1_clk0,
    input  wire                          reset_i,
    input  wire                          req_i,
    input  wire                          we_i,
    input  wire soc_bus_pkg::bus_addr_t  addr_i,
    input  wire soc_bus_pkg::bus_strb_t  wstrb_i,
    input  wire soc_bus_pkg::bus_data_t  wdata_i,
    output logic                         rvalid_o,
    output soc_bus_pkg::bus_data_t       rdata_o,
    output logic [15:0]                  led_o,
    output logic [7:0]                   num_csn_o,
    output logic [7:0]                   num_a_g_o
);

    // Bank 0 is instruction memory, bank 1 data memory
    localparam soc_bus_pkg::bus_addr_t BANK_BASE [`SRAM_BANKS] = '{`SRAM0_BASE, `SRAM1_BASE};

    wire [`SRAM_BANKS-1:0]         sram_sel;
    wire                           conf_sel;
    wire soc_map_pkg::target_e     tgt;
    wire                           rd;
    wire soc_bus_pkg::bus_data_t   sram_rdata [`SRAM_BANKS];
    wire soc_bus_pkg::bus_data_t   conf_rdata;

    bus_decoder bus_decoder_inst (
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .sram_sel_o (sram_sel),
        .conf_sel_o (conf_sel),
        .tgt_o      (tgt),
        .rd_o       (rd)
    );

    for (genvar g = 0; g < `SRAM_BANKS; g++)
    begin : g_bank
        sram_bank #(
            .BASE (BANK_BASE[g])
        ) sram_bank_inst (
            .c1_clk0 (c1_clk0),
            .sel_i   (sram_sel[g]),
            .we_i    (we_i),
            .addr_i  (addr_i),
            .wstrb_i (wstrb_i),
            .wdata_i (wdata_i),
            .rdata_o (sram_rdata[g])
        );
    end

    confreg confreg_inst (
        .c1_clk0   (c1_clk0),
        .reset_i   (reset_i),
        .sel_i     (conf_sel),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .wstrb_i   (wstrb_i),
        .wdata_i   (wdata_i),
        .rdata_o   (conf_rdata),
        .led_o     (led_o),
        .num_csn_o (num_csn_o),
        .num_a_g_o (num_a_g_o)
    );

    read_return read_return_inst (
        .c1_clk0      (c1_clk0),
        .reset_i      (reset_i),
        .rd_i         (rd),
        .tgt_i        (tgt),
        .sram_rdata_i (sram_rdata),
        .conf_rdata_i (conf_rdata),
        .rvalid_o     (rvalid_o),
        .rdata_o      (rdata_o)
    );

endmodule

`default_nettype wire

// File: soc_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top_tb;

    logic                   c1_clk0;
    logic                   reset_i;
    logic                   req_i;
    logic                   we_i;
    soc_bus_pkg::bus_addr_t addr_i;
    soc_bus_pkg::bus_strb_t wstrb_i;
    soc_bus_pkg::bus_data_t wdata_i;
    logic                   rvalid_o;
    soc_bus_pkg::bus_data_t rdata_o;
    logic [15:0]            led_o;
    logic [7:0]             num_csn_o;
    logic [7:0]             num_a_g_o;

    // One entry per test line
    logic [7:0]             op_q    [$];
    soc_bus_pkg::bus_addr_t addr_q  [$];
    soc_bus_pkg::bus_strb_t strb_q  [$];
    soc_bus_pkg::bus_data_t wdata_q [$];
    soc_bus_pkg::bus_data_t exp_q   [$];

    soc_bus_pkg::bus_data_t read_exp_q [$];
    logic                   read_due    = 1'b0;
    int                     cycles      = 0;
    int                     cycle_limit = 0;
    int unsigned            seed;

    soc_top soc_top_inst (
        .c1_clk0   (c1_clk0),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .wstrb_i   (wstrb_i),
        .wdata_i   (wdata_i),
        .rvalid_o  (rvalid_o),
        .rdata_o   (rdata_o),
        .led_o     (led_o),
        .num_csn_o (num_csn_o),
        .num_a_g_o (num_a_g_o)
    );

    initial c1_clk0 = 1'b0;
    always #20 c1_clk0 = ~c1_clk0;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "%s", reason);
    endtask

    // Both SRAM banks fill bfff_0000..bfff_ffff and the registers take 32 bytes
    function automatic logic is_mapped(input logic [31:0] a);
        logic in_sram;
        logic in_conf;
        in_sram = (a >= 32'hbfff_0000) && (a <= 32'hbfff_ffff);
        in_conf = (a >= 32'hbfaf_0000) && (a <= 32'hbfaf_001f);
        is_mapped = in_sram || in_conf;
    endfunction

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] s;
        logic [31:0] d;
        logic [31:0] e;
        fd = $fopen("soc_top_tests.txt", "r");
        if (fd == 0)
            stop_with_error("could not open soc_top_tests.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#")
            begin
                n = $sscanf(line, "%c %h %h %h %h", op, a, s, d, e);
                if (n != 5)
                    stop_with_error({"malformed line in test file: ", line});
                op_q.push_back(op);
                addr_q.push_back(a);
                strb_q.push_back(s[3:0]);
                wdata_q.push_back(d);
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // Drive one test line just after a rising edge
    task automatic run_op(input int i);
        logic [31:0] data;
        data    = wdata_q[i];
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = addr_q[i];
        wstrb_i = strb_q[i];
        case (op_q[i])
            "W":
            begin
                if (!is_mapped(addr_q[i]))
                    data = $urandom();
                req_i = 1'b1;
                we_i  = 1'b1;
            end
            "R":
            begin
                req_i = 1'b1;
                read_exp_q.push_back(exp_q[i]);
            end
            "O":
            begin
                check_value("led_o", {16'h0, led_o}, {16'h0, exp_q[i][31:16]});
                check_value("num_csn_o", {24'h0, num_csn_o}, {24'h0, exp_q[i][15:8]});
                check_value("num_a_g_o", {24'h0, num_a_g_o}, {24'h0, exp_q[i][7:0]});
            end
            default:
                stop_with_error("unknown operation in test file");
        endcase
        wdata_i = data;
    endtask

    // A read taken at this edge must come back before the next one
    always @(posedge c1_clk0)
    begin
        cycles   <= cycles + 1;
        read_due <= req_i && !we_i && !reset_i;
        if (cycle_limit > 0 && cycles >= cycle_limit)
            stop_with_error("timeout, test did not finish within the cycle limit");
    end

    always @(negedge c1_clk0)
    begin
        if (rvalid_o !== read_due)
        begin
            if (read_due)
                stop_with_error("read was accepted but rvalid_o did not follow");
            else
                stop_with_error("rvalid_o went high with no read pending");
        end
        else if (read_due)
        begin
            if (read_exp_q.size() == 0)
                stop_with_error("read returned with no expected value queued");
            check_value("rdata_o", rdata_o, read_exp_q.pop_front());
        end
    end

    initial
    begin
        seed = 32'h2f6f_8160;
        void'($urandom(seed));
        reset_i = 1'b1;
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        wstrb_i = '0;
        wdata_i = '0;
        load_tests();
        cycle_limit = 2 * op_q.size() + 20;
        repeat (2) @(posedge c1_clk0);
        #1;
        reset_i = 1'b0;
        foreach (op_q[i])
        begin
            run_op(i);
            @(posedge c1_clk0);
            #1;
        end
        req_i = 1'b0;
        we_i  = 1'b0;
        // Let the last read come back
        @(posedge c1_clk0);
        #1;
        if (read_exp_q.size() != 0)
        begin
            $display("%0d reads never returned", read_exp_q.size());
            $display("*** FAILED ***");
            $fatal(1, "reads left over at end of run");
        end
        else
        begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: soc_top_tests.txt
# op addr strb wdata expect, all hex; W write, R read, O check outputs
# O expect packs led_o[31:16], num_csn_o[15:8], num_a_g_o[7:0]
O 00000000 0 00000000 0000ff00
W bfff8010 f 11223344 00000000
W bfff0010 f a5a5a5a5 00000000
R bfff8010 0 00000000 11223344
R bfff0010 0 00000000 a5a5a5a5
W bfff8ffc f deadbeef 00000000
R bfff8ffc 0 00000000 deadbeef
# Partial strobes
W bfff8010 5 ffeeddcc 00000000
R bfff8010 0 00000000 11ee33cc
W bfff0010 a 00112233 00000000
R bfff0010 0 00000000 00a522a5
# Register block
W bfaf0000 f 0000abcd 00000000
O 00000000 0 00000000 abcdff00
W bfaf0004 f 000000f0 00000000
W bfaf0008 f 0000005a 00000000
O 00000000 0 00000000 abcdf05a
W bfaf000c f 33333333 00000000
W bfaf0010 f 44444444 00000000
W bfaf0014 f 55555555 00000000
W bfaf0018 f 66666666 00000000
W bfaf001c f 77777777 00000000
R bfaf0000 0 00000000 0000abcd
R bfaf0004 0 00000000 000000f0
R bfaf0008 0 00000000 0000005a
R bfaf000c 0 00000000 33333333
R bfaf0010 0 00000000 44444444
R bfaf0018 0 00000000 66666666
W bfaf0000 2 00001200 00000000
O 00000000 0 00000000 12cdf05a
# Unmapped space, write data is random
R 80000000 0 00000000 00000000
R bfaf0020 0 00000000 00000000
W 80000000 f 00000000 00000000
W bfaf0020 f 00000000 00000000
W bffefffc f 00000000 00000000
# Back to back reads across targets
R bfff8010 0 00000000 11ee33cc
R bfff0010 0 00000000 00a522a5
R bfaf0000 0 00000000 000012cd
R bfff8ffc 0 00000000 deadbeef
R bfaf001c 0 00000000 77777777
R bfaf0014 0 00000000 55555555
O 00000000 0 00000000 12cdf05a

// File: sram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module sram_bank #(
    parameter soc_bus_pkg::bus_addr_t BASE = `SRAM0_BASE
) (
    input  wire                          c1_clk0,
    input  wire                          sel_i,
    input  wire                          we_i,
    input  wire soc_bus_pkg::bus_addr_t  addr_i,
    input  wire soc_bus_pkg::bus_strb_t  wstrb_i,
    input  wire soc_bus_pkg::bus_data_t  wdata_i,
    output soc_bus_pkg::bus_data_t       rdata_o
);

    soc_bus_pkg::bus_data_t   mem [2**`SRAM_AW];
    soc_map_pkg::sram_index_t idx;

    // Word addressed with the byte offset dropped
    assign idx = addr_i[`SRAM_AW+1:2];

    always_ff @(posedge c1_clk0)
    begin
        if (sel_i && we_i)
        begin
            for (int b = 0; b < `BUS_DW/8; b++)
            begin
                if (wstrb_i[b])
                    mem[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
        if (sel_i && !we_i)
            rdata_o <= mem[idx];
    end

    // Decoder must only select this bank inside its own 32 KB window
    assert property (@(posedge c1_clk0) sel_i |-> ((addr_i & `SRAM_MASK) == BASE))
    else $error("sram_bank %h: select outside region at %h", BASE, addr_i);

endmodule

`default_nettype wire
